// ==== flist.f ====
+incdir+hdl
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/playfield_fetch.sv
hdl/video_blend.sv
hdl/video_compositor.sv
verification/video_compositor_tb.sv

// ==== hdl/playfield_fetch.sv ====
`include "video_macros.svh"

module playfield_fetch (
    input  logic                 clk,
    input  video_pkg::pal_wr_t   pal_wr_i,
    input  video_pkg::pos_t      h_pos_i,
    input  video_pkg::pos_t      v_pos_i,
    input  video_pkg::pal_idx_t  scroll_i,
    output video_pkg::argb_t     color_o
);

    import video_pkg::*;

    // palette storage, modeled as a BRAM
    // no reset, contents come from the write port only
    argb_t pal_mem [`VID_PAL_DEPTH];

    pal_idx_t h_low;
    pal_idx_t v_low;
    pal_idx_t rd_idx;

    // low bits of the beam position
    always_comb begin
        h_low = h_pos_i[$bits(pal_idx_t)-1:0];
        v_low = v_pos_i[$bits(pal_idx_t)-1:0];
    end

    // diagonal stripe pattern
    // the sum wraps at the palette depth
    always_comb begin
        rd_idx = h_low + v_low + scroll_i;
    end

    // synchronous write port
    // one entry per strobe
    always_ff @(posedge clk) begin
        if (pal_wr_i.we) begin
            pal_mem[pal_wr_i.addr] <= pal_wr_i.data;
        end
    end

    // registered read
    // a write to the same entry this cycle is not seen yet
    always_ff @(posedge clk) begin
        color_o <= pal_mem[rd_idx];
    end

endmodule

// ==== hdl/video_blend.sv ====
`include "video_macros.svh"

module video_blend (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  video_pkg::vid_ctl_t    ctl_i,
    input  video_pkg::blend_mode_t mode_i,
    input  video_pkg::argb_t       color_a_i,
    input  video_pkg::argb_t       color_b_i,
    output video_pkg::vid_ctl_t    ctl_o,
    output video_pkg::rgb_t        rgb_o
);

    import video_pkg::*;

    localparam int CW = `VID_CHAN_W;

    // stage one, aligned with the palette read
    vid_ctl_t    ctl_1;
    blend_mode_t mode_1;

    // overlay decision for the whole pixel
    logic b_wins;
    // alpha of the top surface
    chan_t alpha_b;
    rgb_t  mixed;

    // one channel of one pixel
    // a is the bottom surface, b the top
    function automatic chan_t mix_chan(
        input blend_mode_t mode,
        input chan_t       ca,
        input chan_t       cb,
        input chan_t       ab,
        input logic        b_top
    );
        logic [2*CW-1:0] wsum;
        logic [CW:0]     asum;
        chan_t           res;
        // weights add up to 16, so the sum stays under 256
        wsum = ({{CW{1'b0}}, ab} + 1'b1) * {{CW{1'b0}}, cb}
             + ({{CW{1'b0}}, {CW{1'b1}}} - {{CW{1'b0}}, ab}) * {{CW{1'b0}}, ca};
        asum = {1'b0, ca} + {1'b0, cb};
        case (mode)
            `BLEND_OVERLAY:   res = b_top ? cb : ca;
            `BLEND_ALPHA:     res = wsum[2*CW-1:CW];
            // saturate on carry out
            `BLEND_ADD_CLAMP: res = asum[CW] ? {CW{1'b1}} : asum[CW-1:0];
            `BLEND_A_ONLY:    res = ca;
            default:          res = ca;
        endcase
        return res;
    endfunction

    // controls and mode wait for the palette lookup
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctl_1  <= '0;
            mode_1 <= `BLEND_OVERLAY;
        end else begin
            ctl_1  <= ctl_i;
            mode_1 <= mode_i;
        end
    end

    // B shows through only where it claims priority and A does not
    always_comb begin
        b_wins  = color_b_i[4*CW-1] & ~color_a_i[4*CW-1];
        alpha_b = color_b_i[4*CW-1:3*CW];
    end

    // per channel mix, red down to blue
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            mixed[c*CW +: CW] = mix_chan(mode_1, color_a_i[c*CW +: CW],
                                         color_b_i[c*CW +: CW], alpha_b, b_wins);
        end
    end

    // stage two, output register
    // blanked pixels forced to black
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctl_o <= '0;
            rgb_o <= '0;
        end else begin
            ctl_o <= ctl_1;
            if (ctl_1.de) begin
                rgb_o <= mixed;
            end else begin
                rgb_o <= '0;
            end
        end
    end

    // no color outside the active window
    assert property (@(posedge clk) disable iff (!arst_n_i)
        !ctl_o.de |-> (rgb_o == '0));

endmodule

// ==== hdl/video_compositor.sv ====
module video_compositor (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  video_pkg::pal_wr_t     pal_wr_i,
    input  logic                   pal_sel_i,
    input  video_pkg::pal_idx_t    scroll_a_i,
    input  video_pkg::pal_idx_t    scroll_b_i,
    input  video_pkg::blend_mode_t mode_i,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   de_o,
    output video_pkg::rgb_t        rgb_o
);

    import video_pkg::*;

    // raster controls at the timing and at the output
    vid_ctl_t tim_ctl;
    vid_ctl_t out_ctl;
    pos_t     h_pos;
    pos_t     v_pos;
    argb_t    color_a;
    argb_t    color_b;
    // per playfield write ports
    pal_wr_t  pal_wr_a;
    pal_wr_t  pal_wr_b;

    // shared address and data
    // strobe goes to the selected playfield only, 0 picks A
    always_comb begin
        pal_wr_a    = pal_wr_i;
        pal_wr_b    = pal_wr_i;
        pal_wr_a.we = pal_wr_i.we & ~pal_sel_i;
        pal_wr_b.we = pal_wr_i.we & pal_sel_i;
    end

    video_timing u_timing (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .ctl_o    (tim_ctl),
        .h_pos_o  (h_pos),
        .v_pos_o  (v_pos)
    );

    // bottom surface
    playfield_fetch u_pf_a (
        .clk      (clk),
        .pal_wr_i (pal_wr_a),
        .h_pos_i  (h_pos),
        .v_pos_i  (v_pos),
        .scroll_i (scroll_a_i),
        .color_o  (color_a)
    );

    // top surface
    playfield_fetch u_pf_b (
        .clk      (clk),
        .pal_wr_i (pal_wr_b),
        .h_pos_i  (h_pos),
        .v_pos_i  (v_pos),
        .scroll_i (scroll_b_i),
        .color_o  (color_b)
    );

    video_blend u_blend (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .ctl_i     (tim_ctl),
        .mode_i    (mode_i),
        .color_a_i (color_a),
        .color_b_i (color_b),
        .ctl_o     (out_ctl),
        .rgb_o     (rgb_o)
    );

    // control levels onto their own pins
    always_comb begin
        hsync_o = out_ctl.hsync;
        vsync_o = out_ctl.vsync;
        de_o    = out_ctl.de;
    end

endmodule

// ==== hdl/video_macros.svh ====
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// horizontal raster in pixels
`define VID_H_ACTIVE 16
`define VID_H_FRONT 2
`define VID_H_SYNC 3
`define VID_H_BACK 3

// vertical raster in lines
`define VID_V_ACTIVE 8
`define VID_V_FRONT 1
`define VID_V_SYNC 2
`define VID_V_BACK 2

// beam counters, wide enough for both totals
`define VID_POS_W 5

// palette entries per playfield
`define VID_PAL_DEPTH 16

// bits per color channel and alpha
`define VID_CHAN_W 4

// run-time blend mode codes
`define BLEND_OVERLAY 2'd0
`define BLEND_ALPHA 2'd1
`define BLEND_ADD_CLAMP 2'd2
`define BLEND_A_ONLY 2'd3

`endif

// ==== hdl/video_pkg.sv ====
`include "video_macros.svh"

package video_pkg;

    // beam coordinate, horizontal or vertical
    typedef logic [`VID_POS_W-1:0] pos_t;

    // palette address
    typedef logic [$clog2(`VID_PAL_DEPTH)-1:0] pal_idx_t;

    // blend mode select, see BLEND_* codes
    typedef logic [1:0] blend_mode_t;

    // one color channel or alpha
    typedef logic [`VID_CHAN_W-1:0] chan_t;

    // red in the top nibble, blue in the bottom
    typedef logic [3*`VID_CHAN_W-1:0] rgb_t;

    // alpha sits above rgb
    typedef logic [4*`VID_CHAN_W-1:0] argb_t;

    // raster control levels, travel together down the pipe
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } vid_ctl_t;

    // palette write port
    // we is a one-cycle strobe
    typedef struct packed {
        logic     we;
        pal_idx_t addr;
        argb_t    data;
    } pal_wr_t;

endpackage

// ==== hdl/video_timing.sv ====
`include "video_macros.svh"

module video_timing (
    input  logic              clk,
    input  logic              arst_n_i,
    output video_pkg::vid_ctl_t ctl_o,
    output video_pkg::pos_t   h_pos_o,
    output video_pkg::pos_t   v_pos_o
);

    import video_pkg::*;

    // raster totals
    localparam int H_TOTAL = `VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK;
    localparam int V_TOTAL = `VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK;

    // region boundaries as counter values
    localparam pos_t H_LAST      = pos_t'(H_TOTAL - 1);
    localparam pos_t V_LAST      = pos_t'(V_TOTAL - 1);
    localparam pos_t H_ACT_END   = pos_t'(`VID_H_ACTIVE);
    localparam pos_t V_ACT_END   = pos_t'(`VID_V_ACTIVE);
    localparam pos_t H_SYNC_BEG  = pos_t'(`VID_H_ACTIVE + `VID_H_FRONT);
    localparam pos_t H_SYNC_END  = pos_t'(`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC);
    localparam pos_t V_SYNC_BEG  = pos_t'(`VID_V_ACTIVE + `VID_V_FRONT);
    localparam pos_t V_SYNC_END  = pos_t'(`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC);

    pos_t     h_cnt;
    pos_t     v_cnt;
    vid_ctl_t ctl_next;

    // free running beam counters
    // vertical steps on the last pixel of each line
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_cnt == H_LAST) begin
                h_cnt <= '0;
                if (v_cnt == V_LAST) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // region decode of the current counts
    always_comb begin
        ctl_next.hsync = (h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END);
        ctl_next.vsync = (v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END);
        // active only inside both active windows
        ctl_next.de    = (h_cnt < H_ACT_END) && (v_cnt < V_ACT_END);
    end

    // levels and position registered together
    // so all outputs describe the same pixel
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctl_o   <= '0;
            h_pos_o <= '0;
            v_pos_o <= '0;
        end else begin
            ctl_o   <= ctl_next;
            h_pos_o <= h_cnt;
            v_pos_o <= v_cnt;
        end
    end

    // display enable never overlaps horizontal sync
    assert property (@(posedge clk) disable iff (!arst_n_i)
        !(ctl_o.de && ctl_o.hsync));

    // each hsync pulse lasts exactly the sync width
    assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(ctl_o.hsync) |-> ctl_o.hsync [*`VID_H_SYNC] ##1 !ctl_o.hsync);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the compositor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module video_compositor_tb \
    -Mdir obj_dir

out=$(./obj_dir/Vvideo_compositor_tb)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi

// ==== verification/video_compositor_tb.sv ====
`include "video_macros.svh"

module video_compositor_tb;

    import video_pkg::*;

    localparam int H_TOTAL = `VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK;
    localparam int V_TOTAL = `VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK;
    localparam int H_SYNC_BEG = `VID_H_ACTIVE + `VID_H_FRONT;
    localparam int H_SYNC_END = H_SYNC_BEG + `VID_H_SYNC;
    localparam int V_SYNC_BEG = `VID_V_ACTIVE + `VID_V_FRONT;
    localparam int V_SYNC_END = V_SYNC_BEG + `VID_V_SYNC;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RESET_CYCLES = 4;
    localparam int LOAD_CYCLES = 2 * `VID_PAL_DEPTH + 8;
    localparam int TEST_FRAMES = 6;
    // one extra frame to reach the first blanking, one spare
    localparam int CYCLE_LIMIT = RESET_CYCLES + LOAD_CYCLES + (TEST_FRAMES + 2) * FRAME_CYCLES;

    logic        clk;
    logic        arst_n_i;
    pal_wr_t     pal_wr;
    logic        pal_sel;
    pal_idx_t    scroll_a;
    pal_idx_t    scroll_b;
    blend_mode_t mode;
    logic        hsync;
    logic        vsync;
    logic        de;
    rgb_t        rgb;

    // mirror palettes, updated with every write
    argb_t pal_a_mdl [`VID_PAL_DEPTH];
    argb_t pal_b_mdl [`VID_PAL_DEPTH];

    integer seed;
    int     errors = 0;
    int     cycles = 0;
    logic   check_en;

    // model beam, the pixel on the outputs after each edge
    int   mdl_warm;
    logic mdl_live;
    int   mdl_h;
    int   mdl_v;

    logic exp_hsync;
    logic exp_vsync;
    logic exp_de;
    rgb_t exp_rgb;

    always #50 clk = ~clk;

    video_compositor dut (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .pal_wr_i   (pal_wr),
        .pal_sel_i  (pal_sel),
        .scroll_a_i (scroll_a),
        .scroll_b_i (scroll_b),
        .mode_i     (mode),
        .hsync_o    (hsync),
        .vsync_o    (vsync),
        .de_o       (de),
        .rgb_o      (rgb)
    );

    // expected pixel from the blend rules, a is bottom and b is top
    function automatic rgb_t blend_ref(input blend_mode_t m, input argb_t a, input argb_t b);
        int   c;
        int   ca;
        int   cb;
        int   ab;
        int   r;
        logic b_top;
        rgb_t res;
        b_top = b[15] && !a[15];
        ab = int'(b[15:12]);
        res = '0;
        for (c = 0; c < 3; c++) begin
            ca = int'(a[4*c +: 4]);
            cb = int'(b[4*c +: 4]);
            case (m)
                `BLEND_OVERLAY:   r = b_top ? cb : ca;
                `BLEND_ALPHA:     r = ((ab + 1) * cb + (15 - ab) * ca) / 16;
                `BLEND_ADD_CLAMP: r = (ca + cb > 15) ? 15 : ca + cb;
                default:          r = ca;
            endcase
            res[4*c +: 4] = 4'(r);
        end
        return res;
    endfunction

    // timing register plus two pipe stages
    // first pixel shows after the third edge
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mdl_warm <= 0;
            mdl_live <= 1'b0;
            mdl_h    <= 0;
            mdl_v    <= 0;
        end else if (mdl_warm < 2) begin
            mdl_warm <= mdl_warm + 1;
        end else if (!mdl_live) begin
            mdl_live <= 1'b1;
        end else if (mdl_h == H_TOTAL - 1) begin
            mdl_h <= 0;
            mdl_v <= (mdl_v == V_TOTAL - 1) ? 0 : mdl_v + 1;
        end else begin
            mdl_h <= mdl_h + 1;
        end
    end

    always_comb begin
        exp_hsync = mdl_live && (mdl_h >= H_SYNC_BEG) && (mdl_h < H_SYNC_END);
        exp_vsync = mdl_live && (mdl_v >= V_SYNC_BEG) && (mdl_v < V_SYNC_END);
        exp_de    = mdl_live && (mdl_h < `VID_H_ACTIVE) && (mdl_v < `VID_V_ACTIVE);
        // index wraps at 16, low four bits of each coordinate
        exp_rgb   = blend_ref(mode,
                              pal_a_mdl[(mdl_h % 16 + mdl_v % 16 + int'(scroll_a)) % 16],
                              pal_b_mdl[(mdl_h % 16 + mdl_v % 16 + int'(scroll_b)) % 16]);
    end

    reset_quiet: assert property (@(posedge clk)
        !arst_n_i |-> (!hsync && !vsync && !de && (rgb == '0)))
        else begin
            errors++;
            $display("** Error: %0t: outputs in reset expected all zero, actual %b %b %b %h",
                     $time, $sampled(hsync), $sampled(vsync), $sampled(de), $sampled(rgb));
        end

    hsync_match: assert property (@(posedge clk) disable iff (!arst_n_i)
        hsync == exp_hsync)
        else begin
            errors++;
            $display("** Error: %0t: hsync_o expected %0b, actual %0b",
                     $time, $sampled(exp_hsync), $sampled(hsync));
        end

    vsync_match: assert property (@(posedge clk) disable iff (!arst_n_i)
        vsync == exp_vsync)
        else begin
            errors++;
            $display("** Error: %0t: vsync_o expected %0b, actual %0b",
                     $time, $sampled(exp_vsync), $sampled(vsync));
        end

    de_match: assert property (@(posedge clk) disable iff (!arst_n_i)
        de == exp_de)
        else begin
            errors++;
            $display("** Error: %0t: de_o expected %0b, actual %0b",
                     $time, $sampled(exp_de), $sampled(de));
        end

    // blanked pixels are black in every mode
    blank_black: assert property (@(posedge clk) disable iff (!arst_n_i)
        !de |-> (rgb == '0))
        else begin
            errors++;
            $display("** Error: %0t: rgb_o expected 000, actual %h", $time, $sampled(rgb));
        end

    rgb_match: assert property (@(posedge clk) disable iff (!arst_n_i)
        (check_en && exp_de) |-> (rgb == exp_rgb))
        else begin
            errors++;
            $display("** Error: %0t: rgb_o expected %h, actual %h",
                     $time, $sampled(exp_rgb), $sampled(rgb));
        end

    // one write strobe per call, mirror follows
    task automatic write_palette(input logic sel, input int idx, input argb_t val);
        @(negedge clk);
        pal_sel      = sel;
        pal_wr.we    = 1'b1;
        pal_wr.addr  = pal_idx_t'(idx);
        pal_wr.data  = val;
        if (sel) begin
            pal_b_mdl[idx] = val;
        end else begin
            pal_a_mdl[idx] = val;
        end
    endtask

    task automatic load_palettes();
        int    i;
        argb_t val;
        for (i = 0; i < `VID_PAL_DEPTH; i++) begin
            val = argb_t'($random(seed));
            // priority bit toggles every entry on A
            val[15] = i[0];
            write_palette(1'b0, i, val);
        end
        for (i = 0; i < `VID_PAL_DEPTH; i++) begin
            val = argb_t'($random(seed));
            // every second pair on B
            val[15] = i[1];
            if (i == 0) begin
                val[15:12] = 4'h0;
            end
            if (i == 3) begin
                val[15:12] = 4'hf;
            end
            // bright entry, sums must clamp
            if (i == 6) begin
                val[11:0] = 12'hfff;
            end
            write_palette(1'b1, i, val);
        end
        @(negedge clk);
        pal_wr.we = 1'b0;
    endtask

    task automatic wait_output_pos(input int v, input int h);
        @(negedge clk);
        while (!(mdl_live && (mdl_v == v) && (mdl_h == h))) begin
            @(negedge clk);
        end
    endtask

    // mode and scroll change while the output is in vertical blanking
    task automatic run_frame(input blend_mode_t m);
        wait_output_pos(`VID_V_ACTIVE + 1, 0);
        mode     = m;
        scroll_a = pal_idx_t'($random(seed));
        scroll_b = pal_idx_t'($random(seed));
        check_en = 1'b1;
        wait_output_pos(`VID_V_ACTIVE, 0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("%0d errors", errors);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        seed      = 32'hb348_9f93;
        clk       = 1'b0;
        arst_n_i  = 1'b0;
        pal_wr    = '0;
        pal_sel   = 1'b0;
        scroll_a  = '0;
        scroll_b  = '0;
        mode      = `BLEND_A_ONLY;
        check_en  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        load_palettes();
        run_frame(`BLEND_A_ONLY);
        run_frame(`BLEND_OVERLAY);
        run_frame(`BLEND_OVERLAY);
        run_frame(`BLEND_ALPHA);
        run_frame(`BLEND_ADD_CLAMP);
        run_frame(`BLEND_A_ONLY);
        repeat (4) @(negedge clk);
        $display("%0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
